// ==== verilog.f ====
+incdir+rtl
rtl/cheat_code_pkg.sv
rtl/cpu_bus_pkg.sv
rtl/code_loader.sv
rtl/code_slot.sv
rtl/patch_merge.sv
rtl/cheat_engine.sv
sim/cheat_engine_chk.sv
sim/cheat_engine_tb.sv

// ==== sim/cheat_engine_tb.sv ====
// Random read and download traffic for the cheat engine
// A four-slot model predicts data_o and available_o every cycle

`timescale 1ns/1ps
`include "cheat_cfg.svh"

module cheat_engine_tb;

	localparam int TIMEOUT_CYCLES = 6000;

	logic                           clk_sys = 1'b0;
	logic                           sys_reset;
	logic                           dl_active_i;
	logic                           dl_wr_i;
	logic [`CHEAT_DL_ADDR_W-1:0]    dl_addr_i;
	logic [`CHEAT_DATA_W-1:0]       dl_data_i;
	logic                           enable_i;
	cpu_bus_pkg::bus_read_t         bus_i;
	logic [`CHEAT_DATA_W-1:0]       data_o;
	logic                           available_o;

	// Model state
	logic [15:0]                    words_m [8];
	logic [`CHEAT_SLOTS-1:0]        valid_m;
	logic                           cmp_en_m [`CHEAT_SLOTS];
	logic [`CHEAT_ADDR_W-1:0]       addr_m [`CHEAT_SLOTS];
	logic [`CHEAT_DATA_W-1:0]       cmp_m [`CHEAT_SLOTS];
	logic [`CHEAT_DATA_W-1:0]       rep_m [`CHEAT_SLOTS];
	logic                           commit_pend = 1'b0;
	logic                           clear_pend = 1'b0;
	logic [`CHEAT_DATA_W-1:0]       exp_data = '0;
	logic                           exp_avail = 1'b0;

	logic [`CHEAT_ADDR_W-1:0]       hot_addr [4];
	logic [`CHEAT_DATA_W-1:0]       hot_data [4];
	int                             errors = 0;
	int                             cycles = 0;

	cheat_engine uut (
		.clk_sys     (clk_sys),
		.sys_reset   (sys_reset),
		.dl_active_i (dl_active_i),
		.dl_wr_i     (dl_wr_i),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.enable_i    (enable_i),
		.bus_i       (bus_i),
		.data_o      (data_o),
		.available_o (available_o)
	);

	initial begin
		forever #50 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////
	// Reference model

	function automatic logic model_hit(input int s);
		return valid_m[s] && bus_i.addr == addr_m[s]
			&& (!cmp_en_m[s] || bus_i.data == cmp_m[s]);
	endfunction

	// Lowest free slot takes the assembled code and a full bank drops it
	task automatic model_commit();
		logic done;
		done = 1'b0;
		for (int s = 0; s < `CHEAT_SLOTS; s++) begin
			if (!valid_m[s] && !done) begin
				valid_m[s]   = 1'b1;
				cmp_en_m[s]  = words_m[0][0];
				addr_m[s]    = {words_m[3][7:0], words_m[2]};
				cmp_m[s]     = words_m[4];
				rep_m[s]     = words_m[6];
				done         = 1'b1;
			end
		end
	endtask

	always @(posedge clk_sys) begin
		logic found;
		found = 1'b0;
		if (sys_reset) begin
			valid_m     = '0;
			exp_data    = '0;
			exp_avail   = 1'b0;
			commit_pend = 1'b0;
			clear_pend  = 1'b0;
		end else begin
			exp_avail = |valid_m;
			exp_data  = bus_i.data;
			for (int s = 0; s < `CHEAT_SLOTS; s++) begin
				if (enable_i && !found && model_hit(s)) begin
					exp_data = rep_m[s];
					found    = 1'b1;
				end
			end
			// Slot state changes one edge after the strobe was seen
			if (clear_pend) begin
				valid_m = '0;
			end else if (commit_pend) begin
				model_commit();
			end
			commit_pend = 1'b0;
			clear_pend  = 1'b0;
			if (dl_active_i && dl_wr_i && dl_addr_i <= `CHEAT_LAST_OFS && !dl_addr_i[0]) begin
				words_m[dl_addr_i[3:1]] = dl_data_i;
				commit_pend = (dl_addr_i == `CHEAT_DL_ADDR_W'(`CHEAT_LAST_OFS));
				clear_pend  = (dl_addr_i == '0);
			end
		end
	end

	// Outputs are stable at the falling edge
	always @(negedge clk_sys) begin
		assert (data_o === exp_data) else begin
			errors++;
			$display("ERR data_o expected %h actual %h", exp_data, data_o);
		end
		assert (available_o === exp_avail) else begin
			errors++;
			$display("ERR available_o expected %h actual %h", exp_avail, available_o);
		end
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the tests did not finish", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus tasks

	task automatic dl_write(input logic [`CHEAT_DL_ADDR_W-1:0] ofs,
			input logic [`CHEAT_DATA_W-1:0] data);
		@(negedge clk_sys);
		dl_wr_i   = 1'b1;
		dl_addr_i = ofs;
		dl_data_i = data;
		@(negedge clk_sys);
		dl_wr_i   = 1'b0;
	endtask

	// Offset 0 goes out only with the first code of a batch and clears the bank
	task automatic load_code(input logic first, input logic cmp_en,
			input logic [23:0] addr, input logic [15:0] cmp, input logic [15:0] rep);
		dl_active_i = 1'b1;
		if (first) begin
			dl_write(0, {15'($urandom), cmp_en});
		end
		dl_write(2, 16'($urandom));
		dl_write(4, addr[15:0]);
		dl_write(6, {8'($urandom), addr[23:16]});
		dl_write(8, cmp);
		dl_write(10, 16'($urandom));
		dl_write(12, rep);
		dl_write(`CHEAT_LAST_OFS, 16'($urandom));
		dl_active_i = 1'b0;
	endtask

	// Mix of random reads and reads at the hot addresses
	task automatic run_reads(input int n);
		int pick;
		int k;
		for (int c = 0; c < n; c++) begin
			@(negedge clk_sys);
			pick = $urandom_range(0, 3);
			k    = $urandom_range(0, 3);
			bus_i.addr = (pick == 0) ? 24'($urandom) : hot_addr[k];
			bus_i.data = (pick >= 2) ? hot_data[k] : 16'($urandom);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		void'($urandom(63977));
		sys_reset   = 1'b1;
		dl_active_i = 1'b0;
		dl_wr_i     = 1'b0;
		dl_addr_i   = '0;
		dl_data_i   = '0;
		enable_i    = 1'b1;
		bus_i       = '0;
		for (int k = 0; k < 4; k++) begin
			hot_addr[k] = 24'($urandom);
			hot_data[k] = 16'($urandom);
		end
		repeat (10) @(posedge clk_sys);
		@(negedge clk_sys);
		sys_reset = 1'b0;

		// Empty bank
		run_reads(500);

		// Unconditional codes
		for (int k = 0; k < 3; k++) begin
			load_code(k == 0, 1'b0, hot_addr[k], 16'($urandom), 16'($urandom));
		end
		run_reads(400);

		// Compare codes with hot data equal to the compare value
		for (int k = 0; k < 3; k++) begin
			hot_addr[k] = 24'($urandom);
			hot_data[k] = 16'($urandom);
			load_code(k == 0, 1'b1, hot_addr[k], hot_data[k], 16'($urandom));
		end
		run_reads(400);

		// Three codes on one address and a fifth code for a full bank
		for (int k = 0; k < 4; k++) begin
			hot_addr[k] = 24'($urandom);
		end
		for (int k = 0; k < 5; k++) begin
			load_code(k == 0, 1'b0, hot_addr[(k < 3) ? 0 : k - 2], 16'($urandom),
				16'($urandom));
		end
		run_reads(300);

		enable_i = 1'b0;
		run_reads(300);
		enable_i = 1'b1;
		run_reads(100);
		// Stray offset 0 write outside a download does nothing
		dl_write(0, 16'($urandom));
		run_reads(50);
		dl_active_i = 1'b1;
		dl_write(0, 16'($urandom));
		dl_active_i = 1'b0;
		run_reads(300);

		@(negedge clk_sys);
		@(posedge clk_sys);
		$display("Errors: model checks %0d, assertions %0d", errors, uut.u_chk.fails);
		if (errors == 0 && uut.u_chk.fails == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== sim/cheat_engine_chk.sv ====
// Concurrent assertions on the cheat engine top level
// Bound into every cheat_engine instance

`timescale 1ns/1ps
`include "cheat_cfg.svh"

module cheat_engine_chk (
	input logic                          clk_sys,
	input logic                          sys_reset,
	input logic                          dl_active_i,
	input logic                          dl_wr_i,
	input logic [`CHEAT_DL_ADDR_W-1:0]   dl_addr_i,
	input logic                          enable_i,
	input cpu_bus_pkg::bus_read_t        bus_i,
	input logic [`CHEAT_DATA_W-1:0]      data_o,
	input logic                          available_o
);

	int   fails = 0;
	logic seen_commit;

	// Set once a final code word has been written since reset
	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			seen_commit <= 1'b0;
		end else if (dl_active_i && dl_wr_i
				&& dl_addr_i == `CHEAT_DL_ADDR_W'(`CHEAT_LAST_OFS)) begin
			seen_commit <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Properties

	a_reset_outputs: assert property (@(posedge clk_sys)
		sys_reset |=> (available_o == 1'b0 && data_o == '0))
		else begin
			fails++;
			$error("outputs not cleared after reset");
		end

	a_avail_needs_commit: assert property (@(posedge clk_sys) disable iff (sys_reset)
		$rose(available_o) |-> seen_commit)
		else begin
			fails++;
			$error("available_o rose without a final code word");
		end

	// Disabled engine is a plain register stage
	a_disabled_passthru: assert property (@(posedge clk_sys) disable iff (sys_reset)
		!enable_i |=> (data_o == $past(bus_i.data)))
		else begin
			fails++;
			$error("data_o differs from bus data while disabled");
		end

endmodule

bind cheat_engine cheat_engine_chk u_chk (
	.clk_sys     (clk_sys),
	.sys_reset   (sys_reset),
	.dl_active_i (dl_active_i),
	.dl_wr_i     (dl_wr_i),
	.dl_addr_i   (dl_addr_i),
	.enable_i    (enable_i),
	.bus_i       (bus_i),
	.data_o      (data_o),
	.available_o (available_o)
);

// ==== rtl/cheat_engine.sv ====
// Top of the cheat patch engine
// Loader feeds a bank of code slots, merge patches the CPU read data

`timescale 1ns/1ps
`include "cheat_cfg.svh"

module cheat_engine (
	input  logic                           clk_sys,
	input  logic                           sys_reset,
	input  logic                           dl_active_i,
	input  logic                           dl_wr_i,
	input  logic [`CHEAT_DL_ADDR_W-1:0]    dl_addr_i,
	input  logic [`CHEAT_DATA_W-1:0]       dl_data_i,
	input  logic                           enable_i,
	input  cpu_bus_pkg::bus_read_t         bus_i,
	output logic [`CHEAT_DATA_W-1:0]       data_o,
	output logic                           available_o
);

	cheat_code_pkg::cheat_code_t                  code;
	logic [`CHEAT_SLOTS-1:0]                      load;
	logic                                         clear;
	logic [`CHEAT_SLOTS-1:0]                      slot_valid;
	logic [`CHEAT_SLOTS-1:0]                      slot_hit;
	logic [`CHEAT_SLOTS-1:0][`CHEAT_DATA_W-1:0]   slot_replace;

	code_loader u_loader (
		.clk_sys      (clk_sys),
		.sys_reset    (sys_reset),
		.dl_active_i  (dl_active_i),
		.dl_wr_i      (dl_wr_i),
		.dl_addr_i    (dl_addr_i),
		.dl_data_i    (dl_data_i),
		.slot_valid_i (slot_valid),
		.code_o       (code),
		.load_o       (load),
		.clear_o      (clear)
	);

	// Code bank, all slots share the code bus and the clear
	for (genvar i = 0; i < `CHEAT_SLOTS; i++) begin : g_slot
		code_slot u_slot (
			.clk_sys   (clk_sys),
			.sys_reset (sys_reset),
			.clear_i   (clear),
			.load_i    (load[i]),
			.code_i    (code),
			.bus_i     (bus_i),
			.valid_o   (slot_valid[i]),
			.hit_o     (slot_hit[i]),
			.replace_o (slot_replace[i])
		);
	end

	patch_merge u_merge (
		.clk_sys     (clk_sys),
		.sys_reset   (sys_reset),
		.bus_i       (bus_i),
		.enable_i    (enable_i),
		.hit_i       (slot_hit),
		.replace_i   (slot_replace),
		.valid_i     (slot_valid),
		.data_o      (data_o),
		.available_o (available_o)
	);

endmodule

// ==== rtl/patch_merge.sv ====
// Picks the winning slot and registers the patched read data
// Also registers the bank-wide codes available flag

`timescale 1ns/1ps
`include "cheat_cfg.svh"

module patch_merge (
	input  logic                                          clk_sys,
	input  logic                                          sys_reset,
	input  cpu_bus_pkg::bus_read_t                        bus_i,
	input  logic                                          enable_i,
	input  logic [`CHEAT_SLOTS-1:0]                       hit_i,
	input  logic [`CHEAT_SLOTS-1:0][`CHEAT_DATA_W-1:0]    replace_i,
	input  logic [`CHEAT_SLOTS-1:0]                       valid_i,
	output logic [`CHEAT_DATA_W-1:0]                      data_o,
	output logic                                          available_o
);

	logic [`CHEAT_DATA_W-1:0] patched;

	// Fixed priority, slot 0 wins
	always_comb begin
		patched = bus_i.data;
		if (enable_i) begin
			for (int i = `CHEAT_SLOTS - 1; i >= 0; i--) begin
				if (hit_i[i]) begin
					patched = replace_i[i];
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Output registers

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			data_o      <= '0;
			available_o <= 1'b0;
		end else begin
			data_o      <= patched;
			available_o <= |valid_i;
		end
	end

endmodule

// ==== rtl/code_slot.sv ====
// One entry of the code bank
// Holds a code and flags a hit when the live read bus matches it

`timescale 1ns/1ps
`include "cheat_cfg.svh"

module code_slot (
	input  logic                         clk_sys,
	input  logic                         sys_reset,
	input  logic                         clear_i,
	input  logic                         load_i,
	input  cheat_code_pkg::cheat_code_t  code_i,
	input  cpu_bus_pkg::bus_read_t       bus_i,
	output logic                         valid_o,
	output logic                         hit_o,
	output logic [`CHEAT_DATA_W-1:0]     replace_o
);

	cheat_code_pkg::cheat_code_t code_q;
	logic                        valid_q;
	logic                        addr_match;
	logic                        data_match;

	////////////////////////////////////////////////////////////
	// Storage

	// Valid bit, clear has priority over a load
	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			valid_q <= 1'b0;
		end else if (clear_i) begin
			valid_q <= 1'b0;
		end else if (load_i) begin
			valid_q <= 1'b1;
		end
	end

	// Code word, taken whole on load
	always_ff @(posedge clk_sys) begin
		if (load_i) begin
			code_q <= code_i;
		end
	end

	////////////////////////////////////////////////////////////
	// Match

	// Only the low bits of the 32-bit fields reach the bus
	assign addr_match = (bus_i.addr == code_q.addr[`CHEAT_ADDR_W-1:0]);
	assign data_match = (bus_i.data == code_q.compare[`CHEAT_DATA_W-1:0]);

	// Compare check only applies with cmp_en set
	assign hit_o = valid_q & addr_match & (~code_q.flags.cmp_en | data_match);

	assign valid_o   = valid_q;
	assign replace_o = code_q.replace[`CHEAT_DATA_W-1:0];

endmodule

// ==== rtl/code_loader.sv ====
// Builds one cheat code from the 16-bit download stream
// Pulses load into the first free slot and clears the bank on offset 0

`timescale 1ns/1ps
`include "cheat_cfg.svh"

module code_loader (
	input  logic                               clk_sys,
	input  logic                               sys_reset,
	input  logic                               dl_active_i,
	input  logic                               dl_wr_i,
	input  logic [`CHEAT_DL_ADDR_W-1:0]        dl_addr_i,
	input  logic [`CHEAT_DATA_W-1:0]           dl_data_i,
	input  logic [`CHEAT_SLOTS-1:0]            slot_valid_i,
	output cheat_code_pkg::cheat_code_t        code_o,
	output logic [`CHEAT_SLOTS-1:0]            load_o,
	output logic                               clear_o
);

	cheat_code_pkg::cheat_code_t code_q;
	logic                        dl_wr;
	logic                        commit_q;
	logic                        clear_q;
	logic [`CHEAT_SLOTS-1:0]     first_free;

	// Strobes outside a code download are ignored
	assign dl_wr = dl_active_i & dl_wr_i;

	////////////////////////////////////////////////////////////
	// Code assembly, low word at the even offset below the high word

	always_ff @(posedge clk_sys) begin
		if (dl_wr) begin
			case (dl_addr_i)
				`CHEAT_DL_ADDR_W'(0):  code_q.flags[15:0]    <= dl_data_i;
				`CHEAT_DL_ADDR_W'(2):  code_q.flags[31:16]   <= dl_data_i;
				`CHEAT_DL_ADDR_W'(4):  code_q.addr[15:0]     <= dl_data_i;
				`CHEAT_DL_ADDR_W'(6):  code_q.addr[31:16]    <= dl_data_i;
				`CHEAT_DL_ADDR_W'(8):  code_q.compare[15:0]  <= dl_data_i;
				`CHEAT_DL_ADDR_W'(10): code_q.compare[31:16] <= dl_data_i;
				`CHEAT_DL_ADDR_W'(12): code_q.replace[15:0]  <= dl_data_i;
				`CHEAT_DL_ADDR_W'(`CHEAT_LAST_OFS): code_q.replace[31:16] <= dl_data_i;
				default: ;
			endcase
		end
	end

	// Commit and clear fire one cycle after their strobe
	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			commit_q <= 1'b0;
			clear_q  <= 1'b0;
		end else begin
			commit_q <= dl_wr && (dl_addr_i == `CHEAT_DL_ADDR_W'(`CHEAT_LAST_OFS));
			clear_q  <= dl_wr && (dl_addr_i == '0);
		end
	end

	// Lowest invalid slot, none when the bank is full
	always_comb begin
		logic found;
		found      = 1'b0;
		first_free = '0;
		for (int i = 0; i < `CHEAT_SLOTS; i++) begin
			if (!slot_valid_i[i] && !found) begin
				first_free[i] = 1'b1;
				found         = 1'b1;
			end
		end
	end

	assign code_o  = code_q;
	assign load_o  = first_free & {`CHEAT_SLOTS{commit_q}};
	assign clear_o = clear_q;

endmodule

// ==== rtl/cpu_bus_pkg.sv ====
// Snooped CPU read bus as seen by the patch logic

`include "cheat_cfg.svh"

package cpu_bus_pkg;

	// One read cycle on the CPU bus
	typedef struct packed {
		// Byte address of the read
		logic [`CHEAT_ADDR_W-1:0] addr;
		// Word returned by memory before patching
		logic [`CHEAT_DATA_W-1:0] data;
	} bus_read_t;

endpackage

// ==== rtl/cheat_code_pkg.sv ====
// Cheat code format as stored in the loader and in every slot
// One code is four 32-bit words sent as eight 16-bit download words

package cheat_code_pkg;

	// Flag word, only bit 0 has a meaning
	typedef struct packed {
		// Kept as downloaded, never decoded
		logic [30:0] reserved;
		// Replace only when bus data equals the compare value
		logic        cmp_en;
	} code_flags_t;

	// Full code, flags in the top word
	// Address uses its low 24 bits, compare and replace their low 16 bits
	typedef struct packed {
		code_flags_t flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

// ==== rtl/cheat_cfg.svh ====
// Build-time sizes for the cheat engine
// Included by every RTL file and by the testbench

`ifndef CHEAT_CFG_SVH
`define CHEAT_CFG_SVH

////////////////////////////////////////////////////////////
// Code bank

// Number of code slots in the bank
`define CHEAT_SLOTS 4

////////////////////////////////////////////////////////////
// CPU bus and download port

// CPU byte address and data word
`define CHEAT_ADDR_W 24
`define CHEAT_DATA_W 16

// Download offset bus
`define CHEAT_DL_ADDR_W 8

// Replace high word, the last word of a code
`define CHEAT_LAST_OFS 14

`endif
